// ==== common/hbus_consts.svh ====
`ifndef HBUS_CONSTS_SVH
`define HBUS_CONSTS_SVH

// Number of DQ pins on the HyperBus
`define HBUS_WIDTH 8

// Initial access latency in clk cycles
`define HBUS_TACC 6

// Reset pulse length on the device reset pin
`define HBUS_RESET_CYCLES 5

// Host address width
`define HBUS_ADDR_W 32

// Idle cycles between transactions
`define HBUS_GAP_CYCLES 3

`endif

// ==== common/hbus_cmd_pkg.sv ====
`include "hbus_consts.svh"

package hbus_cmd_pkg;

    // One host word, sent as two DDR bytes
    typedef logic [15:0] hbus_word_t;

    // One bit per byte, a high bit masks that byte
    typedef logic [1:0] hbus_mask_t;

    // Command/address fields as defined by the HyperBus spec
    typedef struct packed {
        logic        rw;        // 1 read, 0 write
        logic        space;     // 1 register space
        logic        burst;     // 1 linear burst
        logic [28:0] adr_hi;
        logic [12:0] rsvd;
        logic [2:0]  adr_lo;
    } hbus_ca_fields_t;

    // Loaded through the fields, shifted out through the beats
    typedef union packed {
        hbus_ca_fields_t     f;
        hbus_word_t [2:0]    beat;
    } hbus_ca_u;

    // Host request, rd and wr are held until the transaction ends
    typedef struct packed {
        logic                    rd;
        logic                    wr;
        logic                    reg_space;
        logic [`HBUS_ADDR_W-1:0] adr;
        hbus_word_t              wdata;
        hbus_mask_t              wmask;
    } hbus_req_t;

endpackage

// ==== common/hbus_phy_pkg.sv ====
`include "hbus_consts.svh"

package hbus_phy_pkg;

    // Two DQ bytes per clk cycle
    // rise goes out first on the bus
    typedef struct packed {
        logic [`HBUS_WIDTH-1:0] rise;
        logic [`HBUS_WIDTH-1:0] fall;
    } hbus_ddr_t;

    // Pin control from the controller to the PHY
    typedef struct packed {
        logic dq_oe;
        logic rwds_oe;
        logic clk_en;
        logic cs;
    } hbus_oe_t;

endpackage

// ==== hw/hbus_ioddr.sv ====
`timescale 1ns/1ps

module hbus_ioddr #(
    parameter int WIDTH = 8
) (
    input  logic               clk,
    input  logic [2*WIDTH-1:0] dat_i,
    input  logic               oe_i,
    output logic [2*WIDTH-1:0] dat_o,
    inout  wire  [WIDTH-1:0]   pad_io
);

    // Output halves, registered on the rising edge
    logic [WIDTH-1:0] out_rise_q;
    logic [WIDTH-1:0] out_fall_q;
    logic             oe_q;

    // Rise half of an incoming word
    logic [WIDTH-1:0] in_rise_q;

    // Enable is registered with the data so both reach the pad together
    always_ff @(posedge clk) begin
        out_rise_q <= dat_i[2*WIDTH-1:WIDTH];
        out_fall_q <= dat_i[WIDTH-1:0];
        oe_q       <= oe_i;
    end

    // Upper half while clk is high, lower half while it is low
    assign pad_io = oe_q ? (clk ? out_rise_q : out_fall_q) : {WIDTH{1'bz}};

    // The device launches the rise half on the strobe rising edge,
    // so it is stable at the falling edge of clk
    always_ff @(negedge clk) begin
        in_rise_q <= pad_io;
    end

    // Fall half is taken at the next rising edge,
    // which also aligns the pair to clk
    always_ff @(posedge clk) begin
        dat_o <= {in_rise_q, pad_io};
    end

endmodule

// ==== hbus_ctrl/hbus_ctrl.sv ====
`timescale 1ns/1ps
`include "hbus_consts.svh"

module hbus_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  hbus_cmd_pkg::hbus_req_t  req_i,
    input  hbus_phy_pkg::hbus_ddr_t  rx_dat_i,
    input  logic [1:0]               rx_rwds_i,
    output hbus_phy_pkg::hbus_ddr_t  tx_dat_o,
    output logic [1:0]               tx_rwds_o,
    output hbus_phy_pkg::hbus_oe_t   pin_o,
    output logic                     rst_phase_o,
    output logic                     ready_o,
    output logic                     valid_o,
    output hbus_cmd_pkg::hbus_word_t rdata_o
);

    import hbus_cmd_pkg::*;
    import hbus_phy_pkg::*;

    localparam int CNT_W = $clog2(2 * `HBUS_TACC);

    localparam logic [6:0] S_RESET = 7'b0000001;
    localparam logic [6:0] S_IDLE  = 7'b0000010;
    localparam logic [6:0] S_CLKEN = 7'b0000100;
    localparam logic [6:0] S_CMD   = 7'b0001000;
    localparam logic [6:0] S_LAT   = 7'b0010000;
    localparam logic [6:0] S_READ  = 7'b0100000;
    localparam logic [6:0] S_WRITE = 7'b1000000;

    logic [6:0]       state;
    logic [CNT_W-1:0] cnt;
    hbus_ca_u         ca;
    logic             start;
    logic             ca_shift;
    logic             capture;

    // Gap counter must have run out before a new request is taken
    assign start    = (state == S_IDLE) && (cnt == '0) && (req_i.rd || req_i.wr);
    assign ca_shift = (state == S_CMD) && (cnt != '0);

    // A read word is on rx when RWDS shows high then low
    assign capture = (state == S_READ) && req_i.rd && (rx_rwds_i == 2'b10);

    assign rst_phase_o = (state == S_RESET);
    assign ready_o     = (state == S_WRITE) && req_i.wr;

    // CA beats until the write state, then host words
    assign tx_dat_o = (state == S_WRITE) ? req_i.wdata : ca.beat[2];

    // Once wr drops, the trailing beat still in the output register is fully masked
    always_comb begin
        if (state != S_WRITE) begin
            tx_rwds_o = 2'b00;
        end else if (req_i.wr) begin
            tx_rwds_o = req_i.wmask;
        end else begin
            tx_rwds_o = 2'b11;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            ca.f.rw     <= req_i.rd;
            ca.f.space  <= req_i.reg_space;
            ca.f.burst  <= 1'b1;
            ca.f.adr_hi <= req_i.adr[`HBUS_ADDR_W-1:3];
            ca.f.rsvd   <= '0;
            ca.f.adr_lo <= req_i.adr[2:0];
        end else if (ca_shift) begin
            ca.beat <= {ca.beat[1:0], 16'h0000};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_RESET;
            cnt   <= CNT_W'(`HBUS_RESET_CYCLES);
            pin_o <= '0;
        end else begin
            case (state)
                S_RESET: begin
                    if (cnt == '0) begin
                        state <= S_IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end

                S_IDLE: begin
                    if (cnt != '0) begin
                        cnt <= cnt - 1'b1;
                    end else if (start) begin
                        pin_o.cs    <= 1'b1;
                        pin_o.dq_oe <= 1'b1;
                        state       <= S_CLKEN;
                    end
                end

                // Bus clock starts one cycle after csn to trail the DDR register
                S_CLKEN: begin
                    pin_o.clk_en <= 1'b1;
                    cnt          <= CNT_W'(2);
                    state        <= S_CMD;
                end

                S_CMD: begin
                    if (cnt != '0) begin
                        cnt <= cnt - 1'b1;
                    end else begin
                        pin_o.dq_oe <= 1'b0;
                        state       <= S_LAT;
                        // Reads follow the strobe, so a short wait is enough
                        if (req_i.rd) begin
                            cnt <= CNT_W'(`HBUS_TACC - 2);
                        end else if (rx_rwds_i == 2'b11) begin
                            cnt <= CNT_W'(2 * `HBUS_TACC - 3);
                        end else begin
                            cnt <= CNT_W'(`HBUS_TACC - 3);
                        end
                    end
                end

                S_LAT: begin
                    cnt <= cnt - 1'b1;
                    // RWDS preamble is driven low one cycle before the first word
                    if (cnt == CNT_W'(1) && req_i.wr) begin
                        pin_o.rwds_oe <= 1'b1;
                    end
                    if (cnt == '0) begin
                        if (req_i.wr) begin
                            pin_o.dq_oe   <= 1'b1;
                            pin_o.rwds_oe <= 1'b1;
                            state         <= S_WRITE;
                        end else if (req_i.rd) begin
                            state <= S_READ;
                        end else begin
                            pin_o <= '0;
                            cnt   <= CNT_W'(`HBUS_GAP_CYCLES);
                            state <= S_IDLE;
                        end
                    end
                end

                S_READ: begin
                    if (!req_i.rd) begin
                        pin_o <= '0;
                        cnt   <= CNT_W'(`HBUS_GAP_CYCLES);
                        state <= S_IDLE;
                    end
                end

                S_WRITE: begin
                    if (!req_i.wr) begin
                        pin_o <= '0;
                        cnt   <= CNT_W'(`HBUS_GAP_CYCLES);
                        state <= S_IDLE;
                    end
                end

                default: begin
                    pin_o <= '0;
                    cnt   <= CNT_W'(`HBUS_RESET_CYCLES);
                    state <= S_RESET;
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= capture;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            rdata_o <= rx_dat_i;
        end
    end

    // Host must not drive DQ while the device returns data
    a_no_dq_in_read: assert property (@(posedge clk) disable iff (rst)
        (state == S_READ) |-> !pin_o.dq_oe);

    // Write words are only consumed with the device selected
    a_ready_in_cs: assert property (@(posedge clk) disable iff (rst)
        ready_o |-> pin_o.cs);

    a_state_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot(state));

endmodule

// ==== hw/hbus_phy.sv ====
`timescale 1ns/1ps
`include "hbus_consts.svh"

module hbus_phy (
    input  logic                    clk,
    input  logic                    clk90_i,
    input  logic                    rst,
    input  hbus_phy_pkg::hbus_oe_t  pin_i,
    input  logic                    rst_phase_i,
    input  hbus_phy_pkg::hbus_ddr_t tx_dat_i,
    input  logic [1:0]              tx_rwds_i,
    output hbus_phy_pkg::hbus_ddr_t rx_dat_o,
    output logic [1:0]              rx_rwds_o,
    output logic                    hbus_clk_o,
    output logic                    hbus_csn_o,
    output logic                    hbus_rstn_o,
    inout  wire [`HBUS_WIDTH-1:0]   hbus_dq_io,
    inout  wire                     hbus_rwds_io
);

    logic clk_en_meta;
    logic clk_en90;
    logic cs_hold_q;

    hbus_ioddr #(
        .WIDTH(`HBUS_WIDTH)
    ) u_ddr_dq (
        .clk    (clk),
        .dat_i  (tx_dat_i),
        .oe_i   (pin_i.dq_oe),
        .dat_o  (rx_dat_o),
        .pad_io (hbus_dq_io)
    );

    hbus_ioddr #(
        .WIDTH(1)
    ) u_ddr_rwds (
        .clk    (clk),
        .dat_i  (tx_rwds_i),
        .oe_i   (pin_i.rwds_oe),
        .dat_o  (rx_rwds_o),
        .pad_io (hbus_rwds_io)
    );

    // First clk90 edge after clk_en rises falls in the high half of clk,
    // when DQ already carries the first beat
    always_ff @(posedge clk90_i or posedge rst) begin
        if (rst) begin
            clk_en_meta <= 1'b0;
        end else begin
            clk_en_meta <= pin_i.clk_en;
        end
    end

    // Second stage on the falling edge, so the gate only moves while clk90 is low
    always_ff @(negedge clk90_i or posedge rst) begin
        if (rst) begin
            clk_en90 <= 1'b0;
        end else begin
            clk_en90 <= clk_en_meta;
        end
    end

    assign hbus_clk_o = clk90_i & clk_en90;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs_hold_q <= 1'b0;
        end else begin
            cs_hold_q <= pin_i.cs;
        end
    end

    // Deselect one cycle late to cover the last registered DDR beat
    assign hbus_csn_o  = ~(pin_i.cs | cs_hold_q);
    assign hbus_rstn_o = ~rst_phase_i;

    a_clk_in_cs: assert property (@(posedge hbus_clk_o) disable iff (rst)
        !hbus_csn_o);

endmodule

// ==== hw/hbus_top.sv ====
`timescale 1ns/1ps
`include "hbus_consts.svh"

module hbus_top (
    input  logic                     clk,
    input  logic                     clk90_i,
    input  logic                     rst,
    input  hbus_cmd_pkg::hbus_req_t  req_i,
    output logic                     ready_o,
    output logic                     valid_o,
    output hbus_cmd_pkg::hbus_word_t rdata_o,
    output logic                     hbus_clk_o,
    output logic                     hbus_csn_o,
    output logic                     hbus_rstn_o,
    inout  wire [`HBUS_WIDTH-1:0]    hbus_dq_io,
    inout  wire                      hbus_rwds_io
);

    import hbus_phy_pkg::*;

    hbus_oe_t   pin;
    hbus_ddr_t  tx_dat;
    hbus_ddr_t  rx_dat;
    logic [1:0] tx_rwds;
    logic [1:0] rx_rwds;
    logic       rst_phase;

    hbus_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req_i),
        .rx_dat_i    (rx_dat),
        .rx_rwds_i   (rx_rwds),
        .tx_dat_o    (tx_dat),
        .tx_rwds_o   (tx_rwds),
        .pin_o       (pin),
        .rst_phase_o (rst_phase),
        .ready_o     (ready_o),
        .valid_o     (valid_o),
        .rdata_o     (rdata_o)
    );

    hbus_phy u_phy (
        .clk          (clk),
        .clk90_i      (clk90_i),
        .rst          (rst),
        .pin_i        (pin),
        .rst_phase_i  (rst_phase),
        .tx_dat_i     (tx_dat),
        .tx_rwds_i    (tx_rwds),
        .rx_dat_o     (rx_dat),
        .rx_rwds_o    (rx_rwds),
        .hbus_clk_o   (hbus_clk_o),
        .hbus_csn_o   (hbus_csn_o),
        .hbus_rstn_o  (hbus_rstn_o),
        .hbus_dq_io   (hbus_dq_io),
        .hbus_rwds_io (hbus_rwds_io)
    );

endmodule

// ==== tb/hyperram_model.sv ====
`timescale 1ns/1ps
`include "hbus_consts.svh"

module hyperram_model #(
    parameter logic [15:0] ID_VALUE = 16'h0000
) (
    input  logic                   clk_i,
    input  logic                   csn_i,
    input  logic                   rstn_i,
    inout  wire [`HBUS_WIDTH-1:0]  dq_io,
    inout  wire                    rwds_io
);

    logic [15:0]            mem [0:1023];
    logic [47:0]            ca;
    int                     cyc;
    int                     first;
    logic                   is_read;
    logic                   is_reg;
    logic [9:0]             adr;
    logic                   dbl;
    logic                   dbl_next;
    logic [`HBUS_WIDTH-1:0] dq_out;
    logic                   dq_oe;
    logic                   rwds_out;
    logic                   rwds_oe;
    logic [15:0]            rd_word;
    logic [7:0]             wr_hi;
    logic                   wr_hi_mask;

    assign dq_io   = dq_oe ? dq_out : {`HBUS_WIDTH{1'bz}};
    assign rwds_io = rwds_oe ? rwds_out : 1'bz;

    // Power-up contents, every address bit changes the word
    function automatic logic [15:0] fill_word(input int idx);
        logic [31:0] p;
        p = idx * 32'h2f1b;
        return p[15:0] ^ 16'h1357;
    endfunction

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = fill_word(i);
        end
        dq_oe    = 1'b0;
        rwds_oe  = 1'b0;
        rwds_out = 1'b0;
        dbl      = 1'b0;
        dbl_next = 1'b0;
        cyc      = 0;
        first    = 0;
        is_read  = 1'b0;
        is_reg   = 1'b0;
    end

    // Every other transaction asks for double latency on RWDS during CA
    always @(negedge csn_i) begin
        if (rstn_i === 1'b1) begin
            cyc      = 0;
            dbl      = dbl_next;
            dbl_next = ~dbl_next;
            rwds_out = dbl;
            rwds_oe  = 1'b1;
            dq_oe    = 1'b0;
        end
    end

    always @(posedge csn_i) begin
        dq_oe   = 1'b0;
        rwds_oe = 1'b0;
    end

    always @(posedge clk_i) begin
        if (csn_i === 1'b0) begin
            if (cyc < 3) begin
                ca[47-16*cyc -: 8] = dq_io;
            end else if (cyc >= first) begin
                if (is_read) begin
                    rd_word  = is_reg ? ID_VALUE : mem[adr];
                    dq_out   = rd_word[15:8];
                    dq_oe    = 1'b1;
                    rwds_out = 1'b1;
                end else begin
                    wr_hi      = dq_io;
                    wr_hi_mask = rwds_io;
                end
            end
        end
    end

    always @(negedge clk_i) begin
        if (csn_i === 1'b0) begin
            if (cyc < 3) begin
                ca[39-16*cyc -: 8] = dq_io;
                if (cyc == 2) begin
                    is_read = ca[47];
                    is_reg  = ca[46];
                    adr     = {ca[22:16], ca[2:0]};
                    first   = dbl ? 2 * `HBUS_TACC + 1 : `HBUS_TACC + 1;
                    // Reads keep RWDS low through the latency, writes hand it to the host
                    if (is_read) begin
                        rwds_out = 1'b0;
                    end else begin
                        rwds_oe = 1'b0;
                    end
                end
            end else if (cyc >= first) begin
                if (is_read) begin
                    dq_out   = rd_word[7:0];
                    rwds_out = 1'b0;
                end else if (!is_reg) begin
                    if (wr_hi_mask === 1'b0) begin
                        mem[adr][15:8] = wr_hi;
                    end
                    if (rwds_io === 1'b0) begin
                        mem[adr][7:0] = dq_io;
                    end
                end
                adr = adr + 1'b1;
            end
            cyc = cyc + 1;
        end
    end

endmodule

// ==== tb/hbus_tb.sv ====
`timescale 1ns/1ps
`include "hbus_consts.svh"

module hbus_tb;

    import hbus_cmd_pkg::*;

    localparam logic [15:0] ID_VALUE = 16'h0c81;
    localparam int          TIMEOUT  = 200;

    logic                   clk;
    logic                   clk90;
    logic                   rst;
    hbus_req_t              req;
    logic                   ready;
    logic                   valid;
    hbus_word_t             rdata;
    wire                    hbus_clk;
    wire                    csn;
    wire                    rstn;
    wire [`HBUS_WIDTH-1:0]  dq;
    wire                    rwds;

    int          seed;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          errors = 0;
    logic        test_bad = 1'b0;
    logic        timed_out = 1'b0;
    logic [15:0] ref_mem [0:1023];
    hbus_word_t  rd_q[$];
    int          dbl_writes = 0;
    int          dbl_reads = 0;
    int          gaps_checked = 0;
    int          gap_high = 0;
    logic        gap_bad = 1'b0;
    logic        seen_cs = 1'b0;
    logic        csn_prev = 1'b1;

    initial clk = 1'b0;
    always #5 clk = ~clk;
    assign #2.5 clk90 = clk;

    hbus_top dut0 (
        .clk          (clk),
        .clk90_i      (clk90),
        .rst          (rst),
        .req_i        (req),
        .ready_o      (ready),
        .valid_o      (valid),
        .rdata_o      (rdata),
        .hbus_clk_o   (hbus_clk),
        .hbus_csn_o   (csn),
        .hbus_rstn_o  (rstn),
        .hbus_dq_io   (dq),
        .hbus_rwds_io (rwds)
    );

    hyperram_model #(
        .ID_VALUE(ID_VALUE)
    ) ram0 (
        .clk_i   (hbus_clk),
        .csn_i   (csn),
        .rstn_i  (rstn),
        .dq_io   (dq),
        .rwds_io (rwds)
    );

    function automatic logic [15:0] fill_word(input int idx);
        logic [31:0] p;
        p = idx * 32'h2f1b;
        return p[15:0] ^ 16'h1357;
    endfunction

    // Chip select must stay high for the gap between transactions
    always @(negedge clk) begin
        if (rst) begin
            gap_high = 0;
            seen_cs  = 1'b0;
        end else begin
            if (csn === 1'b1) begin
                gap_high++;
            end else if (csn_prev === 1'b1) begin
                if (seen_cs) begin
                    gaps_checked++;
                    if (gap_high < `HBUS_GAP_CYCLES) begin
                        $display("error idle_gap expected %0d actual %0d",
                                 `HBUS_GAP_CYCLES, gap_high);
                        errors++;
                        gap_bad = 1'b1;
                    end
                end
                seen_cs  = 1'b1;
                gap_high = 0;
            end
            csn_prev = csn;
        end
    end

    task automatic check_word(input string name, input logic [15:0] exp,
                              input logic [15:0] act);
        if (exp !== act) begin
            $display("error %s expected %h actual %h", name, exp, act);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic note_timeout(input string name, input string what);
        $display("%s timed out waiting for %s", name, what);
        timed_out = 1'b1;
        test_bad  = 1'b1;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_bad) begin
            tests_failed++;
            $display("test %s failed", name);
        end else begin
            $display("test %s done ok", name);
        end
        test_bad = 1'b0;
    endtask

    task automatic wait_csn_high(input string name);
        int t;
        t = 0;
        while (csn !== 1'b1 && t < TIMEOUT) begin
            @(negedge clk);
            t++;
            if (valid === 1'b1) begin
                $display("%s got a read word after the burst was closed", name);
                test_bad = 1'b1;
            end
        end
        if (csn !== 1'b1) begin
            note_timeout(name, "chip select to rise");
        end
    endtask

    task automatic write_burst(input string name, input logic [9:0] addr,
                               input int n, input logic mask_en);
        hbus_word_t w[8];
        hbus_mask_t m[8];
        int         k;
        int         t;
        logic       pending;
        for (k = 0; k < n; k++) begin
            w[k] = $random(seed);
            m[k] = mask_en ? 2'($random(seed)) : 2'b00;
            if (!m[k][1]) begin
                ref_mem[addr + k][15:8] = w[k][15:8];
            end
            if (!m[k][0]) begin
                ref_mem[addr + k][7:0] = w[k][7:0];
            end
        end
        req.adr       = `HBUS_ADDR_W'(addr);
        req.reg_space = 1'b0;
        req.wdata     = w[0];
        req.wmask     = m[0];
        req.wr        = 1'b1;
        k       = 0;
        t       = 0;
        pending = 1'b0;
        // A word shown with ready high is taken on the next rising edge
        while (k < n && t < TIMEOUT) begin
            @(negedge clk);
            t++;
            if (pending) begin
                k++;
                if (k < n) begin
                    req.wdata = w[k];
                    req.wmask = m[k];
                end
            end
            pending = ready;
        end
        req.wr = 1'b0;
        if (k < n) begin
            note_timeout(name, "write data to be taken");
        end else begin
            if (ram0.dbl) begin
                dbl_writes++;
            end
            wait_csn_high(name);
        end
    endtask

    task automatic read_burst(input string name, input logic [9:0] addr,
                              input int n, input logic reg_space);
        int t;
        rd_q.delete();
        req.adr       = `HBUS_ADDR_W'(addr);
        req.reg_space = reg_space;
        req.rd        = 1'b1;
        t = 0;
        while (rd_q.size() < n && t < TIMEOUT) begin
            @(negedge clk);
            t++;
            if (valid === 1'b1) begin
                rd_q.push_back(rdata);
            end
        end
        req.rd        = 1'b0;
        req.reg_space = 1'b0;
        if (rd_q.size() < n) begin
            note_timeout(name, "read data");
        end else begin
            if (ram0.dbl) begin
                dbl_reads++;
            end
            wait_csn_high(name);
        end
    endtask

    task automatic verify_range(input string name, input logic [9:0] addr, input int n);
        read_burst(name, addr, n, 1'b0);
        for (int k = 0; k < rd_q.size(); k++) begin
            check_word(name, ref_mem[addr + k], rd_q[k]);
        end
    endtask

    task automatic reset_test();
        int t;
        int low_cnt;
        repeat (10) begin
            @(negedge clk);
            if (csn !== 1'b1 || ready !== 1'b0 || valid !== 1'b0 || rstn !== 1'b0) begin
                $display("reset pins were active while rst was held");
                test_bad = 1'b1;
            end
        end
        rst     = 1'b0;
        low_cnt = 1;
        t       = 0;
        while (rstn !== 1'b1 && t < TIMEOUT) begin
            @(negedge clk);
            t++;
            if (rstn !== 1'b1) begin
                low_cnt++;
            end
            if (csn !== 1'b1 || ready !== 1'b0 || valid !== 1'b0) begin
                $display("bus was active during the device reset phase");
                test_bad = 1'b1;
            end
        end
        if (rstn !== 1'b1) begin
            note_timeout("reset", "device reset release");
        end
        check_word("reset", 16'(`HBUS_RESET_CYCLES + 1), 16'(low_cnt));
    endtask

    initial begin
        logic [31:0] r;
        logic [9:0]  addr;
        int          n;
        logic        mask_en;
        string       name;
        seed = 32'hb571;
        req  = '0;
        rst  = 1'b1;
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = fill_word(i);
        end

        reset_test();
        finish_test("reset");

        for (int i = 0; i < 12; i++) begin
            if (!timed_out) begin
                // Extra single reads shift which transactions get double latency
                if (i == 1 || ($random(seed) & 1)) begin
                    r    = $random(seed);
                    name = $sformatf("single_read_%0d", i);
                    verify_range(name, r[9:0], 1);
                    finish_test(name);
                end
                r       = $random(seed);
                addr    = (r[9:0] > 10'd1015) ? r[9:0] - 10'd8 : r[9:0];
                n       = ($random(seed) & 7) + 1;
                mask_en = (i >= 6);
                name    = $sformatf("%s_%0d", mask_en ? "masked_burst" : "burst", i);
                write_burst(name, addr, n, mask_en);
                if (!timed_out) begin
                    verify_range(name, addr, n);
                end
                finish_test(name);
            end
        end

        if (!timed_out) begin
            r = $random(seed);
            read_burst("reg_read", r[9:0], 1, 1'b1);
            if (rd_q.size() > 0) begin
                check_word("reg_read", ID_VALUE, rd_q[0]);
            end
            finish_test("reg_read");
            verify_range("reg_mem_check", (r[9:0] > 10'd1015) ? 10'd1015 : r[9:0], 8);
            finish_test("reg_mem_check");
        end

        if (dbl_writes == 0 || dbl_reads == 0) begin
            $display("double latency was not seen on both writes and reads");
            test_bad = 1'b1;
        end
        finish_test("double_latency");

        if (gaps_checked == 0) begin
            $display("no gap between transactions was observed");
            test_bad = 1'b1;
        end
        test_bad = test_bad | gap_bad;
        finish_test("idle_gap");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0 && !timed_out) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+common
common/hbus_cmd_pkg.sv
common/hbus_phy_pkg.sv
hw/hbus_ioddr.sv
hbus_ctrl/hbus_ctrl.sv
hw/hbus_phy.sv
hw/hbus_top.sv
tb/hyperram_model.sv
tb/hbus_tb.sv
